/* fm_timer_pkg.sv */
/* fm timer package
   register map, control bit positions, timer widths and the structs
   passed between the register slave and the timer pair */
`default_nettype none

package fm_timer_pkg;

    // ####################################################################
    // bus and register map
    // ####################################################################

    // wishbone classic, byte wide
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 8;

    // timer a value is split over two registers like the original chip
    localparam logic [WB_ADR_W-1:0] ADDR_CLKA_HI = 8'h10;
    localparam logic [WB_ADR_W-1:0] ADDR_CLKA_LO = 8'h11;
    localparam logic [WB_ADR_W-1:0] ADDR_CLKB    = 8'h12;
    localparam logic [WB_ADR_W-1:0] ADDR_CTRL    = 8'h14;

    // control register bits
    localparam int CTRL_LOAD_A  = 0;
    localparam int CTRL_LOAD_B  = 1;
    localparam int CTRL_IRQEN_A = 2;
    localparam int CTRL_IRQEN_B = 3;
    localparam int CTRL_CLRF_A  = 4;
    localparam int CTRL_CLRF_B  = 5;

    // ####################################################################
    // timer geometry
    // ####################################################################

    // timer a: 10 bit count behind a /64 prescaler
    localparam int TA_CNT_W = 10;
    localparam int TA_PRE_W = 6;
    // timer b: 8 bit count behind a /1024 prescaler
    localparam int TB_CNT_W = 8;
    localparam int TB_PRE_W = 10;

    // clk cycles per timer tick
    localparam int CEN_DIV   = 2;
    localparam int CEN_CNT_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    // ####################################################################
    // shared structs
    // ####################################################################

    // command to one timer, only meaningful in a cen cycle
    typedef struct packed {
        logic load;
        logic clr_run;
        logic clr_flag;
    } timer_cmd_t;

    // register contents seen by the timers
    typedef struct packed {
        logic [TA_CNT_W-1:0] value_a;
        logic [TB_CNT_W-1:0] value_b;
        logic                irq_en_a;
        logic                irq_en_b;
    } timer_cfg_t;

    // status returned on a bus read
    typedef struct packed {
        logic flag_a;
        logic flag_b;
    } timer_stat_t;

endpackage

`default_nettype wire

/* fm_cen_gen.sv */
/* timer tick divider
   produces a one clk wide enable once every CEN_DIV clocks */
`timescale 1ns/1ps
`default_nettype none

module fm_cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    // free running phase counter
    logic [fm_timer_pkg::CEN_CNT_W-1:0] div_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else begin
            // wrap at CEN_DIV - 1 so the ratio need not be a power of two
            if (div_cnt == fm_timer_pkg::CEN_CNT_W'(fm_timer_pkg::CEN_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // tick on phase zero
    // first tick lands in the first clk after reset release
    assign cen = (div_cnt == '0);

endmodule

`default_nettype wire

/* fm_timer.sv */
/* prescaled up-counter with reload
   counts from start_value while running, flags and reloads on carry-out */
`timescale 1ns/1ps
`default_nettype none

module fm_timer #(
    parameter int cnt_w = 10,
    parameter int pre_w = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  logic [cnt_w-1:0]         start_value,
    input  fm_timer_pkg::timer_cmd_t cmd,
    output logic                     flag,
    output logic                     overflow
);

    logic                   run;
    // counter and prescaler as one word, counter in the upper bits
    logic [cnt_w+pre_w-1:0] count;
    logic [cnt_w+pre_w-1:0] count_inc;
    logic [cnt_w+pre_w-1:0] count_init;
    logic                   carry;

    // ####################################################################
    // count path
    // ####################################################################

    // carry out of the combined word marks the overflow tick
    assign {carry, count_inc} = {1'b0, count} + (cnt_w + pre_w + 1)'(1);
    // reload value, prescaler restarts at zero
    assign count_init = {start_value, {pre_w{1'b0}}};

    always_ff @(posedge clk) begin
        if (cen) begin
            if (cmd.load) begin
                count <= count_init;
            end else if (run) begin
                count <= carry ? count_init : count_inc;
            end
        end
    end

    // ####################################################################
    // run state and flag
    // ####################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run  <= 1'b0;
            flag <= 1'b0;
        end else if (cen) begin
            // stop wins, although the slave never sends both
            if (cmd.clr_run) begin
                run <= 1'b0;
            end else if (cmd.load) begin
                run <= 1'b1;
            end
            // sticky until cleared, clear has priority
            if (cmd.clr_flag) begin
                flag <= 1'b0;
            end else if (run && carry) begin
                flag <= 1'b1;
            end
        end
    end

    // one clk pulse in the overflow tick
    assign overflow = cen & run & carry;

    // the register slave must resolve a load and a stop before the tick
    load_stop_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(cmd.load && cmd.clr_run)
    );

endmodule

`default_nettype wire

/* fm_timer_pair.sv */
/* timers a and b with the interrupt combine
   irq_n goes low while any enabled flag is set */
`timescale 1ns/1ps
`default_nettype none

module fm_timer_pair (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  fm_timer_pkg::timer_cfg_t  cfg,
    input  fm_timer_pkg::timer_cmd_t  cmd_a,
    input  fm_timer_pkg::timer_cmd_t  cmd_b,
    output fm_timer_pkg::timer_stat_t stat,
    output logic                      overflow_a,
    output logic                      irq_n
);

    logic flag_a;
    logic flag_b;

    // ####################################################################
    // timers
    // ####################################################################

    // timer a, period (1024 - value_a) * 64 ticks
    fm_timer #(
        .cnt_w (fm_timer_pkg::TA_CNT_W),
        .pre_w (fm_timer_pkg::TA_PRE_W)
    ) u_timer_a (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .start_value (cfg.value_a),
        .cmd         (cmd_a),
        .flag        (flag_a),
        .overflow    (overflow_a)
    );

    // timer b, period (256 - value_b) * 1024 ticks
    // its overflow pulse has no user in this block
    fm_timer #(
        .cnt_w (fm_timer_pkg::TB_CNT_W),
        .pre_w (fm_timer_pkg::TB_PRE_W)
    ) u_timer_b (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .start_value (cfg.value_b),
        .cmd         (cmd_b),
        .flag        (flag_b),
        .overflow    ()
    );

    // ####################################################################
    // status and interrupt
    // ####################################################################

    assign stat.flag_a = flag_a;
    assign stat.flag_b = flag_b;

    // combinational so irq_n follows the flag in the same clk
    assign irq_n = ~((flag_a & cfg.irq_en_a) | (flag_b & cfg.irq_en_b));

endmodule

`default_nettype wire

/* fm_timer_regs.sv */
/* wishbone classic slave for the timer registers
   holds values and enables, turns control writes into tick-aligned commands */
`timescale 1ns/1ps
`default_nettype none

module fm_timer_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cen,
    // wishbone classic slave
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [fm_timer_pkg::WB_ADR_W-1:0]   adr,
    input  logic [fm_timer_pkg::WB_DAT_W-1:0]   dat_w,
    output logic [fm_timer_pkg::WB_DAT_W-1:0]   dat_r,
    output logic                                ack,
    // timer side
    input  fm_timer_pkg::timer_stat_t           stat,
    output fm_timer_pkg::timer_cfg_t            cfg,
    output fm_timer_pkg::timer_cmd_t            cmd_a,
    output fm_timer_pkg::timer_cmd_t            cmd_b
);

    // register contents
    logic [fm_timer_pkg::TA_CNT_W-1:0] value_a;
    logic [fm_timer_pkg::TB_CNT_W-1:0] value_b;
    logic                              irq_en_a;
    logic                              irq_en_b;

    // running state implied by the last load bits written
    logic run_a;
    logic run_b;

    // commands waiting for the next tick
    fm_timer_pkg::timer_cmd_t pend_a;
    fm_timer_pkg::timer_cmd_t pend_b;
    fm_timer_pkg::timer_cmd_t held_a;
    fm_timer_pkg::timer_cmd_t held_b;

    logic req;
    logic wr_hi;
    logic wr_lo;
    logic wr_b;
    logic wr_ctrl;

    // ####################################################################
    // bus decode
    // ####################################################################

    // new request only when not already acking it
    assign req     = cyc & stb & ~ack;
    assign wr_hi   = req & we & (adr == fm_timer_pkg::ADDR_CLKA_HI);
    assign wr_lo   = req & we & (adr == fm_timer_pkg::ADDR_CLKA_LO);
    assign wr_b    = req & we & (adr == fm_timer_pkg::ADDR_CLKB);
    assign wr_ctrl = req & we & (adr == fm_timer_pkg::ADDR_CTRL);

    // single cycle ack, one clk after the request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // every address reads back status
    always_ff @(posedge clk) begin
        if (req && !we) begin
            dat_r <= {{(fm_timer_pkg::WB_DAT_W - 2){1'b0}}, stat.flag_b, stat.flag_a};
        end
    end

    // ####################################################################
    // value registers
    // ####################################################################

    always_ff @(posedge clk) begin
        // high byte goes to bits 9..2, low write fills bits 1..0
        if (wr_hi) begin
            value_a[fm_timer_pkg::TA_CNT_W-1:2] <= dat_w;
        end
        if (wr_lo) begin
            value_a[1:0] <= dat_w[1:0];
        end
        if (wr_b) begin
            value_b <= dat_w;
        end
    end

    // ####################################################################
    // control and pending commands
    // ####################################################################

    // fold one control write into the commands already held
    function automatic fm_timer_pkg::timer_cmd_t merge_cmd(
        input fm_timer_pkg::timer_cmd_t held,
        input logic                     running,
        input logic                     load_bit,
        input logic                     clrf_bit
    );
        fm_timer_pkg::timer_cmd_t nxt;
        nxt = held;
        if (load_bit) begin
            // load only a stopped timer, a running one keeps its period
            if (!running) begin
                nxt.load    = 1'b1;
                nxt.clr_run = 1'b0;
            end
        end else begin
            // a later stop cancels a load still waiting
            nxt.load    = 1'b0;
            nxt.clr_run = 1'b1;
        end
        if (clrf_bit) begin
            nxt.clr_flag = 1'b1;
        end
        return nxt;
    endfunction

    // whatever is presented this tick is gone after it
    assign held_a = cen ? '0 : pend_a;
    assign held_b = cen ? '0 : pend_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
            run_a    <= 1'b0;
            run_b    <= 1'b0;
            pend_a   <= '0;
            pend_b   <= '0;
        end else if (wr_ctrl) begin
            irq_en_a <= dat_w[fm_timer_pkg::CTRL_IRQEN_A];
            irq_en_b <= dat_w[fm_timer_pkg::CTRL_IRQEN_B];
            // load bit set means running from here on, clear means stopped
            run_a    <= dat_w[fm_timer_pkg::CTRL_LOAD_A];
            run_b    <= dat_w[fm_timer_pkg::CTRL_LOAD_B];
            pend_a   <= merge_cmd(held_a, run_a, dat_w[fm_timer_pkg::CTRL_LOAD_A],
                                  dat_w[fm_timer_pkg::CTRL_CLRF_A]);
            pend_b   <= merge_cmd(held_b, run_b, dat_w[fm_timer_pkg::CTRL_LOAD_B],
                                  dat_w[fm_timer_pkg::CTRL_CLRF_B]);
        end else begin
            pend_a <= held_a;
            pend_b <= held_b;
        end
    end

    // commands are only visible in a cen cycle
    assign cmd_a = cen ? pend_a : '0;
    assign cmd_b = cen ? pend_b : '0;

    assign cfg = '{
        value_a:  value_a,
        value_b:  value_b,
        irq_en_a: irq_en_a,
        irq_en_b: irq_en_b
    };

    // the master holds stb through ack, so ack must drop on its own
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    );

endmodule

`default_nettype wire

/* fm_timer_top.sv */
/* fm timer block top level
   tick divider, wishbone register slave and timer pair */
`timescale 1ns/1ps
`default_nettype none

module fm_timer_top (
    input  logic                              clk,
    input  logic                              rst,
    // wishbone classic slave
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [fm_timer_pkg::WB_ADR_W-1:0] adr,
    input  logic [fm_timer_pkg::WB_DAT_W-1:0] dat_w,
    output logic [fm_timer_pkg::WB_DAT_W-1:0] dat_r,
    output logic                              ack,
    // timer outputs
    output logic                              irq_n,
    output logic                              overflow_a
);

    logic                      cen;
    fm_timer_pkg::timer_cfg_t  cfg;
    fm_timer_pkg::timer_cmd_t  cmd_a;
    fm_timer_pkg::timer_cmd_t  cmd_b;
    fm_timer_pkg::timer_stat_t stat;

    // slow internal tick
    fm_cen_gen u_cen (
        .clk (clk),
        .rst (rst),
        .cen (cen)
    );

    // bus side, commands leave aligned to cen
    fm_timer_regs u_regs (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .stat  (stat),
        .cfg   (cfg),
        .cmd_a (cmd_a),
        .cmd_b (cmd_b)
    );

    // ####################################################################
    // timers and interrupt
    // ####################################################################

    fm_timer_pair u_pair (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .cfg        (cfg),
        .cmd_a      (cmd_a),
        .cmd_b      (cmd_b),
        .stat       (stat),
        .overflow_a (overflow_a),
        .irq_n      (irq_n)
    );

endmodule

`default_nettype wire

/* tb_fm_timer.sv */
/* fm timer block testbench
   lfsr picked timer values, periods and flags checked against a timing model */
`timescale 1ns/1ps
`default_nettype none

module tb_fm_timer;

    localparam int CD = fm_timer_pkg::CEN_DIV;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [7:0]  dat_w;
    logic [7:0]  dat_r;
    logic        ack;
    logic        irq_n;
    logic        overflow_a;
    // clk edges so far, read 1 ns after an edge
    int          cyc_cnt = 0;
    // edge count of the last overflow_a pulse seen
    int          last_pulse;
    logic [15:0] lfsr_state;

    fm_timer_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .irq_n      (irq_n),
        .overflow_a (overflow_a)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // ####################################################################
    // checks, random values and the timing model
    // ####################################################################

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_failed();
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: %s", what);
        stop_failed();
    endtask

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    // n random bits, one lfsr step per bit
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    // clocks between overflows: (2^cnt_w - value) * 2^pre_w ticks of CD clocks
    function automatic int period_clks(input int cnt_w, input int pre_w, input int value);
        return ((1 << cnt_w) - value) * (1 << pre_w) * CD;
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic load_a, input logic load_b,
                                             input logic irq_en_a, input logic clrf_a,
                                             input logic clrf_b);
        logic [7:0] b;
        b = 8'h00;
        b[fm_timer_pkg::CTRL_LOAD_A]  = load_a;
        b[fm_timer_pkg::CTRL_LOAD_B]  = load_b;
        b[fm_timer_pkg::CTRL_IRQEN_A] = irq_en_a;
        b[fm_timer_pkg::CTRL_CLRF_A]  = clrf_a;
        b[fm_timer_pkg::CTRL_CLRF_B]  = clrf_b;
        return b;
    endfunction

    // ####################################################################
    // wishbone master
    // ####################################################################

    // one classic cycle, returns 1 ns after the ack edge
    task automatic bus_cycle(input logic wr, input logic [7:0] a, input logic [7:0] d,
                             output logic [7:0] q);
        int n;
        int edges;
        n     = 0;
        // ack one clk after the request, a still high ack delays the request by one clk
        edges = (ack === 1'b1) ? 2 : 1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        // ack of a previous cycle may still be high, so always pass one edge
        do begin
            if (n == 8) begin
                timed_out("no ack on the wishbone bus");
            end
            @(posedge clk);
            #1;
            n++;
        end while (ack !== 1'b1);
        compare("ack clocks", 32'(n), 32'(edges));
        q   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        logic [7:0] ignored;
        bus_cycle(1'b1, a, d, ignored);
    endtask

    task automatic read_status(output logic [7:0] q);
        bus_cycle(1'b0, fm_timer_pkg::ADDR_CTRL, 8'h00, q);
    endtask

    // timer a value split over the high and low registers
    task automatic write_value_a(input int v);
        write_reg(fm_timer_pkg::ADDR_CLKA_HI, 8'(v >> 2));
        write_reg(fm_timer_pkg::ADDR_CLKA_LO, 8'(v & 3));
    endtask

    // ####################################################################
    // timing waits
    // ####################################################################

    // first overflow_a in [lo, hi] clocks after t0, none before lo
    task automatic await_pulse(input int t0, input int lo, input int hi);
        int dt;
        do begin
            @(posedge clk);
            #1;
            dt = cyc_cnt - t0;
            if (dt < lo) begin
                compare("overflow_a", 32'(overflow_a), 32'h0);
            end else if (dt > hi) begin
                timed_out("overflow_a pulse missing after the load");
            end
        end while (overflow_a !== 1'b1);
        last_pulse = cyc_cnt;
    endtask

    // next overflow_a exactly period clocks after the last, quiet in between
    task automatic expect_next_pulse(input int period);
        while (cyc_cnt < last_pulse + period) begin
            @(posedge clk);
            #1;
            compare("overflow_a", 32'(overflow_a), 32'(cyc_cnt == last_pulse + period));
        end
        last_pulse = cyc_cnt;
    endtask

    // poll status until flag b, which must not show before lo
    task automatic await_flag_b(input int t0, input int lo, input int hi);
        int         dt;
        logic [7:0] q;
        do begin
            read_status(q);
            dt = cyc_cnt - t0;
            if (dt < lo) begin
                compare("dat_r.flag_b", 32'(q[1]), 32'h0);
            end else if (dt > hi) begin
                timed_out("flag b did not rise within the predicted window");
            end
        end while (q[1] !== 1'b1);
    endtask

    // ####################################################################
    // test sequence
    // ####################################################################

    initial begin
        int         t0;
        int         n;
        int         val_a;
        int         val_b;
        int         per_a;
        int         per_b;
        logic [7:0] rd;
        clk        = 1'b0;
        rst        = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = 8'h00;
        dat_w      = 8'h00;
        lfsr_state = 16'd50;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset state
        compare("irq_n", 32'(irq_n), 32'h1);
        compare("overflow_a", 32'(overflow_a), 32'h0);
        compare("ack", 32'(ack), 32'h0);
        read_status(rd);
        compare("dat_r", 32'(rd), 32'h0);

        // timer a period, first pulse within the load delay
        val_a = 1000 + rand_bits(5) % 24;
        per_a = period_clks(fm_timer_pkg::TA_CNT_W, fm_timer_pkg::TA_PRE_W, val_a);
        write_value_a(val_a);
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        t0 = cyc_cnt;
        await_pulse(t0, per_a, per_a + CD);
        expect_next_pulse(per_a);

        // flag rises one clk after the pulse, irq only when enabled
        @(posedge clk);
        #1;
        compare("irq_n", 32'(irq_n), 32'h1);
        read_status(rd);
        compare("dat_r", 32'(rd), 32'h1);
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
        compare("irq_n", 32'(irq_n), 32'h0);
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b1, 1'b0));
        n = 0;
        while (irq_n !== 1'b1) begin
            if (n == CD + 2) begin
                timed_out("irq_n stayed low after the flag a clear");
            end
            @(posedge clk);
            #1;
            n++;
        end
        read_status(rd);
        compare("dat_r", 32'(rd), 32'h0);

        // timer b load, flag within the predicted window
        val_b = 252 + rand_bits(2);
        per_b = period_clks(fm_timer_pkg::TB_CNT_W, fm_timer_pkg::TB_PRE_W, val_b);
        write_reg(fm_timer_pkg::ADDR_CLKB, 8'(val_b));
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
        t0 = cyc_cnt;
        await_flag_b(t0, per_b - 2 * CD, per_b + 2 * CD);

        // stop both timers and clear both flags
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b1));
        // a pulse is still legal until the stop reaches a tick
        repeat (CD) @(posedge clk);
        #1;
        for (int i = 0; i < 2 * per_a; i++) begin
            @(posedge clk);
            #1;
            compare("overflow_a", 32'(overflow_a), 32'h0);
        end
        read_status(rd);
        compare("dat_r", 32'(rd), 32'h0);

        // reload a, then a load bit on the running timer keeps the period
        val_a = 1000 + rand_bits(5) % 24;
        per_a = period_clks(fm_timer_pkg::TA_CNT_W, fm_timer_pkg::TA_PRE_W, val_a);
        write_value_a(val_a);
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        t0 = cyc_cnt;
        await_pulse(t0, per_a, per_a + CD);
        write_reg(fm_timer_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        expect_next_pulse(per_a);
        expect_next_pulse(per_a);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
fm_timer_pkg.sv
fm_cen_gen.sv
fm_timer.sv
fm_timer_pair.sv
fm_timer_regs.sv
fm_timer_top.sv
tb_fm_timer.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and search the output for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_fm_timer \
    -f sim.f -o tb_fm_timer_sim &&
./obj_dir/tb_fm_timer_sim | tee /dev/stderr | grep -q "^Simulation passed$" &&
echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
